//--- hdl/l1_cache_pkg.sv
// ************************************************************
// l1 cache package
// word and block widths, bus structs and controller states
// shared by the cache controller, sequencer and set array
// ************************************************************

package l1_cache_pkg;

    localparam int WORD_BITS   = 32;
    localparam int BLOCK_WORDS = 2;   // memory bus moves one whole block

    typedef logic [WORD_BITS-1:0]             word_t;
    typedef logic [WORD_BITS/8-1:0]           byte_en_t;
    typedef logic [BLOCK_WORDS*WORD_BITS-1:0] block_t;   // word 0 in the low bits

    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic   ren;
        logic   wen;
        word_t  addr;   // block aligned
        block_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        SWEEP_INIT,
        SERVE,
        WRITE_BACK,
        REFILL,
        FLUSH
    } ctrl_state_t;

endpackage

//--- hdl/tag_data_array.sv
// ************************************************************
// tag/data set array
// one frame per set: tag, valid, dirty and block data
// async read, masked write per field and per data byte
// ************************************************************
`timescale 1ns/100ps

module tag_data_array #(
    parameter int  CACHE_BYTES = 1024,
    localparam int BLOCK_BYTES = l1_cache_pkg::BLOCK_WORDS * l1_cache_pkg::WORD_BITS / 8,
    localparam int N_SETS      = CACHE_BYTES / BLOCK_BYTES,
    localparam int IDX_BITS    = $clog2(N_SETS),
    localparam int TAG_BITS    = l1_cache_pkg::WORD_BITS - IDX_BITS - $clog2(BLOCK_BYTES),
    localparam int MASK_BITS   = 3 + BLOCK_BYTES
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [IDX_BITS-1:0]  set_sel,
    input  logic                 wr_en,
    input  logic [TAG_BITS-1:0]  wr_tag,
    input  logic                 wr_valid,
    input  logic                 wr_dirty,
    input  l1_cache_pkg::block_t wr_data,
    input  logic [MASK_BITS-1:0] wr_mask,   // {data bytes, dirty, valid, tag}
    output logic [TAG_BITS-1:0]  rd_tag,
    output logic                 rd_valid,
    output logic                 rd_dirty,
    output l1_cache_pkg::block_t rd_data
);

    typedef logic [TAG_BITS-1:0] tag_t;

    tag_t                 tag_mem   [N_SETS];
    logic                 valid_mem [N_SETS];
    logic                 dirty_mem [N_SETS];
    l1_cache_pkg::block_t data_mem  [N_SETS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            if (wr_mask[0]) tag_mem[set_sel] <= wr_tag;
            if (wr_mask[1]) valid_mem[set_sel] <= wr_valid;
            if (wr_mask[2]) dirty_mem[set_sel] <= wr_dirty;
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                if (wr_mask[3 + b]) data_mem[set_sel][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    assign rd_tag   = tag_mem[set_sel];
    assign rd_valid = valid_mem[set_sel];
    assign rd_dirty = dirty_mem[set_sel];
    assign rd_data  = data_mem[set_sel];

    // a write to an unknown set would corrupt an arbitrary frame
    a_wr_sel_known: assert property (@(posedge CLK) disable iff (!nRST)
        wr_en |-> !$isunknown(set_sel))
        else $error("set array written with unknown set select");

endmodule

//--- hdl/sweep_sequencer.sv
// ************************************************************
// sweep sequencer
// set counter for the reset sweep and the flush sweep,
// plus the pending flush request flag
// ************************************************************
`timescale 1ns/100ps

module sweep_sequencer #(
    parameter int  CACHE_BYTES = 1024,
    localparam int BLOCK_BYTES = l1_cache_pkg::BLOCK_WORDS * l1_cache_pkg::WORD_BITS / 8,
    localparam int N_SETS      = CACHE_BYTES / BLOCK_BYTES,
    localparam int IDX_BITS    = $clog2(N_SETS)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                sweep_clear,
    input  logic                sweep_step,
    input  logic                flush,
    input  logic                flush_taken,
    output logic [IDX_BITS-1:0] sweep_set,
    output logic                sweep_last,
    output logic                flush_pending
);

    logic [IDX_BITS-1:0] set_cnt;
    logic                flush_req;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set_cnt   <= '0;   // reset sweep starts at set 0
            flush_req <= 1'b0;
        end else begin
            if (sweep_clear) begin
                set_cnt <= '0;
            end else if (sweep_step) begin
                set_cnt <= set_cnt + 1'b1;
            end
            // a new pulse wins over the take of an older one
            flush_req <= flush | (flush_req & ~flush_taken);
        end
    end

    assign sweep_set     = set_cnt;
    assign sweep_last    = (set_cnt == IDX_BITS'(N_SETS - 1));
    assign flush_pending = flush_req;

    // the controller must close every sweep on its last set
    a_no_wrap: assert property (@(posedge CLK) disable iff (!nRST)
        (sweep_step && sweep_last) |-> sweep_clear)
        else $error("sweep stepped past the last set");

endmodule

//--- hdl/cache_ctrl.sv
// ************************************************************
// cache controller
// hit detection and byte merge on the processor side,
// write-back / refill on misses, reset and flush sweeps
// ************************************************************
`timescale 1ns/100ps

module cache_ctrl #(
    parameter int  CACHE_BYTES = 1024,
    localparam int WORD_BYTES  = l1_cache_pkg::WORD_BITS / 8,
    localparam int BLOCK_BYTES = l1_cache_pkg::BLOCK_WORDS * WORD_BYTES,
    localparam int N_SETS      = CACHE_BYTES / BLOCK_BYTES,
    localparam int IDX_BITS    = $clog2(N_SETS),
    localparam int OFF_BITS    = $clog2(BLOCK_BYTES),
    localparam int TAG_BITS    = l1_cache_pkg::WORD_BITS - IDX_BITS - OFF_BITS,
    localparam int MASK_BITS   = 3 + BLOCK_BYTES
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_rsp_t cpu_rsp,
    output l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp,
    output logic [IDX_BITS-1:0]    set_sel,
    output logic                   wr_en,
    output logic [TAG_BITS-1:0]    wr_tag,
    output logic                   wr_valid,
    output logic                   wr_dirty,
    output l1_cache_pkg::block_t   wr_data,
    output logic [MASK_BITS-1:0]   wr_mask,
    input  logic [TAG_BITS-1:0]    rd_tag,
    input  logic                   rd_valid,
    input  logic                   rd_dirty,
    input  l1_cache_pkg::block_t   rd_data,
    input  logic [IDX_BITS-1:0]    sweep_set,
    input  logic                   sweep_last,
    input  logic                   flush_pending,
    output logic                   sweep_clear,
    output logic                   sweep_step,
    output logic                   flush_taken,
    output logic                   flush_done
);

    localparam int WO_BITS = $clog2(l1_cache_pkg::BLOCK_WORDS);
    localparam int BO_BITS = $clog2(WORD_BYTES);

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [IDX_BITS-1:0] set_idx_t;

    typedef struct packed {
        tag_t                 tag;
        set_idx_t             idx;
        logic [WO_BITS-1:0]   word_off;
        logic [BO_BITS-1:0]   byte_off;
    } addr_fields_t;

    l1_cache_pkg::ctrl_state_t state, next_state;
    addr_fields_t              req_f;
    logic                      req_any;
    logic                      hit;
    logic                      victim_dirty;
    logic                      sweep_adv;   // current sweep set is finished
    l1_cache_pkg::byte_en_t    lane_en;
    logic [BLOCK_BYTES-1:0]    data_mask;

    assign req_f        = addr_fields_t'(cpu_req.addr);
    assign req_any      = cpu_req.ren | cpu_req.wen;
    assign hit          = rd_valid && (rd_tag == req_f.tag);
    assign victim_dirty = rd_valid && rd_dirty;

    // only the listed lane patterns merge, the rest store the whole word
    always_comb begin
        case (cpu_req.byte_en)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: lane_en = cpu_req.byte_en;
            default: lane_en = '1;
        endcase
    end

    assign data_mask = BLOCK_BYTES'(lane_en) << (WORD_BYTES * req_f.word_off);

    assign cpu_rsp.rdata = rd_data[req_f.word_off * l1_cache_pkg::WORD_BITS +:
                                   l1_cache_pkg::WORD_BITS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= l1_cache_pkg::SWEEP_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        cpu_rsp.busy  = 1'b1;
        mem_req.ren   = 1'b0;
        mem_req.wen   = 1'b0;
        mem_req.addr  = '0;
        mem_req.wdata = rd_data;
        set_sel       = req_f.idx;
        wr_en         = 1'b0;
        wr_tag        = '0;
        wr_valid      = 1'b0;
        wr_dirty      = 1'b0;
        wr_data       = '0;
        wr_mask       = '0;
        sweep_adv     = 1'b0;
        flush_taken   = 1'b0;
        flush_done    = 1'b0;

        case (state)
            l1_cache_pkg::SWEEP_INIT: begin
                set_sel   = sweep_set;
                wr_en     = 1'b1;   // zero the whole frame
                wr_mask   = '1;
                sweep_adv = 1'b1;
                if (sweep_last) next_state = l1_cache_pkg::SERVE;
            end
            l1_cache_pkg::SERVE: begin
                if (req_any && hit) begin
                    cpu_rsp.busy = 1'b0;
                    if (cpu_req.wen) begin
                        wr_en    = 1'b1;
                        wr_dirty = 1'b1;
                        wr_data  = {l1_cache_pkg::BLOCK_WORDS{cpu_req.wdata}};
                        wr_mask  = {data_mask, 3'b100};
                    end
                end else if (flush_pending) begin
                    flush_taken = 1'b1;
                    next_state  = l1_cache_pkg::FLUSH;
                end else if (req_any) begin
                    next_state = victim_dirty ? l1_cache_pkg::WRITE_BACK
                                              : l1_cache_pkg::REFILL;
                end
            end
            l1_cache_pkg::WRITE_BACK: begin
                mem_req.wen  = 1'b1;
                mem_req.addr = {rd_tag, req_f.idx, {OFF_BITS{1'b0}}};   // victim block
                if (!mem_rsp.busy) begin
                    wr_en      = 1'b1;
                    wr_mask    = {{BLOCK_BYTES{1'b0}}, 3'b110};   // drop valid and dirty
                    next_state = l1_cache_pkg::REFILL;
                end
            end
            l1_cache_pkg::REFILL: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = {req_f.tag, req_f.idx, {OFF_BITS{1'b0}}};
                if (!mem_rsp.busy) begin
                    wr_en      = 1'b1;
                    wr_tag     = req_f.tag;
                    wr_valid   = 1'b1;
                    wr_data    = mem_rsp.rdata;
                    wr_mask    = '1;
                    next_state = l1_cache_pkg::SERVE;   // request replays as a hit
                end
            end
            l1_cache_pkg::FLUSH: begin
                set_sel = sweep_set;
                if (victim_dirty) begin
                    mem_req.wen  = 1'b1;
                    mem_req.addr = {rd_tag, sweep_set, {OFF_BITS{1'b0}}};
                end
                // clean sets go in one cycle, dirty ones wait for memory
                if (!victim_dirty || !mem_rsp.busy) begin
                    wr_en     = 1'b1;
                    wr_mask   = '1;
                    sweep_adv = 1'b1;
                    if (sweep_last) begin
                        flush_done = 1'b1;
                        next_state = l1_cache_pkg::SERVE;
                    end
                end
            end
            default: begin
                next_state = l1_cache_pkg::SWEEP_INIT;
            end
        endcase
    end

    assign sweep_step  = sweep_adv & ~sweep_last;
    assign sweep_clear = sweep_adv & sweep_last;

    // miss handling rereads the request address across several cycles
    a_cpu_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (req_any && cpu_rsp.busy) |=> $stable(cpu_req))
        else $error("processor request changed while busy");

    // a transfer keeps one direction and one address until accepted
    a_mem_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req))
        else $error("memory request changed before it was accepted");

endmodule

//--- hdl/l1_cache.sv
// ************************************************************
// l1 data cache top
// direct mapped, write back; joins the controller,
// the sweep sequencer and the tag/data set array
// ************************************************************
`timescale 1ns/100ps

module l1_cache #(
    parameter int CACHE_BYTES = 1024   // power of two
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_rsp_t cpu_rsp,
    input  logic                   flush,
    output logic                   flush_done,
    output l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp
);

    localparam int BLOCK_BYTES = l1_cache_pkg::BLOCK_WORDS * l1_cache_pkg::WORD_BITS / 8;
    localparam int N_SETS      = CACHE_BYTES / BLOCK_BYTES;
    localparam int IDX_BITS    = $clog2(N_SETS);
    localparam int TAG_BITS    = l1_cache_pkg::WORD_BITS - IDX_BITS - $clog2(BLOCK_BYTES);
    localparam int MASK_BITS   = 3 + BLOCK_BYTES;

    // array ports
    logic [IDX_BITS-1:0]  set_sel;
    logic                 wr_en;
    logic [TAG_BITS-1:0]  wr_tag;
    logic                 wr_valid;
    logic                 wr_dirty;
    l1_cache_pkg::block_t wr_data;
    logic [MASK_BITS-1:0] wr_mask;
    logic [TAG_BITS-1:0]  rd_tag;
    logic                 rd_valid;
    logic                 rd_dirty;
    l1_cache_pkg::block_t rd_data;

    // sequencer handshake
    logic [IDX_BITS-1:0]  sweep_set;
    logic                 sweep_last;
    logic                 sweep_clear;
    logic                 sweep_step;
    logic                 flush_pending;
    logic                 flush_taken;

    cache_ctrl #(.CACHE_BYTES(CACHE_BYTES)) u_ctrl (.*);

    sweep_sequencer #(.CACHE_BYTES(CACHE_BYTES)) u_seq (.*);

    tag_data_array #(.CACHE_BYTES(CACHE_BYTES)) u_array (.*);

endmodule

//--- verif/tb_clock.sv
// ************************************************************
// testbench clock and reset
// free running clock, active low reset for a few cycles
// ************************************************************
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;   // released on a falling edge
    end

    always #(PERIOD_NS / 2.0) CLK = ~CLK;

endmodule

//--- verif/cache_checker.sv
// ************************************************************
// cache checker
// flat word model of memory; checks every completed read
// and the memory contents once a flush finishes
// ************************************************************
`timescale 1ns/100ps

module cache_checker #(
    parameter int MODEL_WORDS = 1024
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::cpu_req_t cpu_req,
    input  l1_cache_pkg::cpu_rsp_t cpu_rsp,
    input  logic                   flush_done,
    input  l1_cache_pkg::mem_req_t mem_req,
    input  l1_cache_pkg::mem_rsp_t mem_rsp,
    input  logic [8*16-1:0]        test_name,
    output int                     error_count,
    output int                     read_count,
    output int                     flush_count
);

    l1_cache_pkg::word_t model    [MODEL_WORDS];   // processor view
    l1_cache_pkg::word_t mem_seen [MODEL_WORDS];   // memory view, from write-backs
    logic                touched  [MODEL_WORDS];

    function automatic l1_cache_pkg::word_t initial_word(int unsigned widx);
        return ((l1_cache_pkg::word_t'(widx) << 2) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic l1_cache_pkg::word_t merge_word(l1_cache_pkg::word_t old_w,
                                                       l1_cache_pkg::word_t new_w,
                                                       l1_cache_pkg::byte_en_t be);
        l1_cache_pkg::byte_en_t lanes;
        l1_cache_pkg::word_t    merged;
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: lanes = be;
            default: lanes = '1;   // other patterns store the whole word
        endcase
        merged = old_w;
        for (int k = 0; k < 4; k++) begin
            if (lanes[k]) merged[8*k +: 8] = new_w[8*k +: 8];
        end
        return merged;
    endfunction

    initial begin
        error_count = 0;
        read_count  = 0;
        flush_count = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model[i]    = initial_word(i);
            mem_seen[i] = initial_word(i);
            touched[i]  = 1'b0;
        end
    end

    always @(posedge CLK) begin : watch
        int widx;
        if (nRST && (cpu_req.ren || cpu_req.wen) && !cpu_rsp.busy) begin
            widx = int'(cpu_req.addr >> 2) % MODEL_WORDS;
            touched[widx] = 1'b1;
            if (cpu_req.wen) begin
                model[widx] = merge_word(model[widx], cpu_req.wdata, cpu_req.byte_en);
            end else begin
                read_count++;
                if (cpu_rsp.rdata !== model[widx]) begin
                    error_count++;
                    $display("ERROR %0s: read 0x%08h expected 0x%08h actual 0x%08h",
                             test_name, cpu_req.addr, model[widx], cpu_rsp.rdata);
                end
            end
        end
        if (nRST && mem_req.wen && !mem_rsp.busy) begin
            widx = int'(mem_req.addr >> 2) % MODEL_WORDS;   // block aligned
            for (int w = 0; w < l1_cache_pkg::BLOCK_WORDS; w++) begin
                mem_seen[widx + w] = mem_req.wdata[w*32 +: 32];
            end
        end
        // last write-back lands on the same edge as flush_done
        if (nRST && flush_done) begin
            flush_count++;
            for (int i = 0; i < MODEL_WORDS; i++) begin
                if (touched[i] && mem_seen[i] !== model[i]) begin
                    error_count++;
                    $display("ERROR %0s: memory word 0x%08h expected 0x%08h actual 0x%08h",
                             test_name, i * 4, model[i], mem_seen[i]);
                end
            end
        end
    end

endmodule

//--- verif/l1_cache_tb.sv
// ************************************************************
// l1 cache testbench
// random processor traffic, block memory with random latency,
// flush sequence and watchdog
// ************************************************************
`timescale 1ns/100ps

module l1_cache_tb;

    localparam int CACHE_BYTES = 1024;
    localparam int N_SETS      = CACHE_BYTES / 8;
    localparam int SEED        = 31234;
    localparam int MAX_LATENCY = 5;
    localparam int POOL_WORDS  = 32;   // 4 tags x 4 sets x 2 words
    localparam int N_RANDOM    = 200;
    localparam int N_OPS       = 4 * POOL_WORDS + 16 + N_RANDOM;
    localparam int WDOG_CYCLES = N_OPS * 40 + N_SETS * 10;
    localparam int MEM_WORDS   = 1024;

    logic                   CLK;
    logic                   nRST;
    l1_cache_pkg::cpu_req_t cpu_req;
    l1_cache_pkg::cpu_rsp_t cpu_rsp;
    logic                   flush;
    logic                   flush_done;
    l1_cache_pkg::mem_req_t mem_req;
    l1_cache_pkg::mem_rsp_t mem_rsp;
    logic [8*16-1:0]        test_name;
    int                     error_count;
    int                     read_count;
    int                     flush_count;
    int                     tb_errors    = 0;
    int                     reads_issued = 0;
    int                     tests_run    = 0;
    int                     test_base    = 0;
    l1_cache_pkg::word_t    mem_words [MEM_WORDS];
    int                     busy_left;
    logic                   in_service;

    tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(3)) u_clock (.CLK(CLK), .nRST(nRST));

    l1_cache #(.CACHE_BYTES(CACHE_BYTES)) DUT (.*);

    cache_checker #(.MODEL_WORDS(MEM_WORDS)) u_checker (.*);

    function automatic l1_cache_pkg::word_t fill_word(int unsigned widx);
        return ((l1_cache_pkg::word_t'(widx) << 2) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    // sel bits {tag[1:0], set[1:0], word}, tag field starts at bit 10
    function automatic l1_cache_pkg::word_t pool_addr(int unsigned sel);
        return ((sel >> 3) << 10) | (((sel >> 1) & 3) << 3) | ((sel & 1) << 2);
    endfunction

    task automatic cpu_access(input logic is_write, input l1_cache_pkg::word_t addr,
                              input l1_cache_pkg::word_t data,
                              input l1_cache_pkg::byte_en_t be);
        cpu_req.ren     = ~is_write;
        cpu_req.wen     = is_write;
        cpu_req.addr    = addr;
        cpu_req.wdata   = data;
        cpu_req.byte_en = be;
        @(posedge CLK);
        while (cpu_rsp.busy) @(posedge CLK);   // done on the edge with busy low
        @(negedge CLK);
        cpu_req.ren = 1'b0;
        cpu_req.wen = 1'b0;
        if (!is_write) reads_issued++;
    endtask

    task automatic start_test(input logic [8*16-1:0] name);
        test_name = name;
        test_base = error_count + tb_errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %0s finished, %0d errors", test_name, error_count + tb_errors - test_base);
    endtask

    initial begin
        mem_rsp.busy  = 1'b1;
        mem_rsp.rdata = '0;
        in_service    = 1'b0;
        busy_left     = 0;
        for (int i = 0; i < MEM_WORDS; i++) mem_words[i] = fill_word(i);
    end

    // block memory; busy drops for one edge per transfer
    always @(negedge CLK) begin : mem_responder
        int base;
        base = int'(mem_req.addr[11:3]) * 2;
        if (!mem_rsp.busy) begin
            mem_rsp.busy = 1'b1;   // transfer took the last edge
        end else if (nRST && (mem_req.ren || mem_req.wen)) begin
            if (!in_service) begin
                in_service = 1'b1;
                busy_left  = $urandom_range(MAX_LATENCY);
            end
            if (busy_left == 0) begin
                in_service   = 1'b0;
                mem_rsp.busy = 1'b0;
                if (mem_req.wen) begin
                    mem_words[base]     = mem_req.wdata[31:0];
                    mem_words[base + 1] = mem_req.wdata[63:32];
                end else begin
                    mem_rsp.rdata = {mem_words[base + 1], mem_words[base]};
                end
            end else begin
                busy_left--;
            end
        end
    end

    initial begin : stimulus
        l1_cache_pkg::byte_en_t be_list [8];
        l1_cache_pkg::word_t    addr;
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111, 4'b0110};
        void'($urandom(SEED));
        cpu_req = '0;
        flush   = 1'b0;
        @(posedge nRST);
        @(negedge CLK);

        start_test("reset_reads");
        for (int i = 0; i < POOL_WORDS; i++) cpu_access(1'b0, pool_addr(i), '0, '1);
        end_test();

        start_test("byte_merge");
        for (int k = 0; k < 8; k++) begin
            addr = pool_addr($urandom_range(POOL_WORDS - 1));
            cpu_access(1'b1, addr, $urandom, be_list[k]);
            cpu_access(1'b0, addr, '0, '1);
        end
        end_test();

        start_test("evict_sets");   // same sets, other tags, dirty victims
        for (int i = 0; i < POOL_WORDS; i++) cpu_access(1'b1, pool_addr(i), $urandom, 4'hF);
        for (int i = 0; i < POOL_WORDS; i++) cpu_access(1'b0, pool_addr(i), '0, '1);
        end_test();

        start_test("random_mix");
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = pool_addr($urandom_range(POOL_WORDS - 1));
            if ($urandom_range(1) == 1) cpu_access(1'b1, addr, $urandom, $urandom_range(15));
            else cpu_access(1'b0, addr, '0, '1);
        end
        end_test();

        start_test("flush");
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        @(posedge CLK);
        while (!flush_done) @(posedge CLK);
        repeat (4) @(negedge CLK);   // room for a stray second pulse
        if (flush_count != 1) begin
            tb_errors++;
            $display("ERROR flush: flush_done pulses expected 1 actual %0d", flush_count);
        end
        end_test();

        start_test("post_flush");
        for (int i = 0; i < POOL_WORDS; i++) cpu_access(1'b0, pool_addr(i), '0, '1);
        if (read_count != reads_issued) begin
            tb_errors++;
            $display("ERROR post_flush: read completions expected %0d actual %0d",
                     reads_issued, read_count);
        end
        end_test();

        $display("%0d tests, %0d reads, %0d errors", tests_run, read_count,
                 error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge CLK);
        $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- all.f
hdl/l1_cache_pkg.sv
hdl/tag_data_array.sv
hdl/sweep_sequencer.sv
hdl/cache_ctrl.sv
hdl/l1_cache.sv
verif/tb_clock.sv
verif/cache_checker.sv
verif/l1_cache_tb.sv

//--- Bender.yml
package:
  name: l1_cache

sources:
  - hdl/l1_cache_pkg.sv
  - hdl/tag_data_array.sv
  - hdl/sweep_sequencer.sv
  - hdl/cache_ctrl.sv
  - hdl/l1_cache.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/cache_checker.sv
      - verif/l1_cache_tb.sv
